/* src/rv_core_pkg.sv */
package rv_core_pkg;

    // register file and datapath width of the RV32 core
    localparam int DATA_BITS = 32;

    // physical register file has 64 entries
    localparam int PHYS_TAG_BITS = 6;

    // number of unresolved branches the core can track at once
    localparam int BRANCH_DEPTH = 4;

    typedef logic [DATA_BITS-1:0]     data_t;
    typedef logic [PHYS_TAG_BITS-1:0] phys_reg_t;

    // one bit per in-flight branch the instruction depends on
    typedef logic [BRANCH_DEPTH-1:0] branch_mask_t;

    // M extension multiply functions, RV32 only
    typedef enum logic [1:0] {
        MUL    = 2'd0, // low word, sign does not matter
        MULH   = 2'd1, // high word, signed x signed
        MULHSU = 2'd2, // high word, signed x unsigned
        MULHU  = 2'd3  // high word, unsigned x unsigned
    } mult_func_t;

    // packet handed over by the issue stage
    typedef struct packed {
        data_t        source_1;
        data_t        source_2;
        mult_func_t   func;
        phys_reg_t    dest_tag;
        branch_mask_t branch_mask;
    } mult_issue_t;

    // result broadcast on the common data bus
    typedef struct packed {
        data_t        result;
        phys_reg_t    dest_tag;
        branch_mask_t branch_mask;
    } cdb_packet_t;

    // an instruction dies when it depends on any mispredicted branch
    function automatic logic branch_killed(
        input branch_mask_t mask,
        input branch_mask_t squash
    );
        return |(mask & squash);
    endfunction

    // correctly predicted branches drop out of every dependent mask
    function automatic branch_mask_t branch_cleared(
        input branch_mask_t mask,
        input branch_mask_t clear
    );
        return mask & ~clear;
    endfunction

endpackage

/* src/mult_pkg.sv */
package mult_pkg;

    // the full product of two 32-bit operands
    localparam int PRODUCT_BITS = 2 * rv_core_pkg::DATA_BITS;

    // number of pipeline stages between issue and the CDB
    localparam int MULT_STAGES = 4;

    // each stage consumes this many multiplier bits
    localparam int SLICE_BITS = PRODUCT_BITS / MULT_STAGES;

    typedef logic [PRODUCT_BITS-1:0] product_t;
    typedef logic [SLICE_BITS-1:0]   slice_t;

    // packet that moves from stage to stage
    // the multiplier shifts right and the multiplicand shifts left by one
    // slice per stage, so every stage always works on the low slice
    typedef struct packed {
        product_t                  partial_sum;  // running sum of the slices so far
        product_t                  multiplier;   // bits not yet consumed
        product_t                  multiplicand; // aligned to the next slice
        rv_core_pkg::mult_func_t   func;
        rv_core_pkg::phys_reg_t    dest_tag;
        rv_core_pkg::branch_mask_t branch_mask;
    } mult_work_t;

endpackage

/* src/mult_stage.sv */
`timescale 1ns/1ns

module mult_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  mult_pkg::mult_work_t      in_work,
    output logic                      out_valid,
    input  logic                      out_ready,
    output mult_pkg::mult_work_t      out_work,
    input  rv_core_pkg::branch_mask_t squash_mask,
    input  rv_core_pkg::branch_mask_t clear_mask
);
    import rv_core_pkg::*;
    import mult_pkg::*;

    logic       valid_q;
    mult_work_t work_q;
    mult_work_t next_work;
    slice_t     slice;
    logic       in_killed;
    logic       held_killed;

    assign in_killed   = branch_killed(in_work.branch_mask, squash_mask);
    assign held_killed = branch_killed(work_q.branch_mask, squash_mask);

    // a stage can take a new packet when it is empty or its packet moves on this cycle
    assign in_ready = !valid_q || out_ready;

    // a squash withdraws the held packet right away, not at the next edge
    assign out_valid = valid_q && !held_killed;
    assign out_work  = work_q;

    // add one slice of partial product and move both operands to the next slice
    always_comb begin
        slice                  = in_work.multiplier[SLICE_BITS-1:0];
        next_work              = in_work;
        next_work.partial_sum  = in_work.partial_sum + product_t'(slice) * in_work.multiplicand;
        next_work.multiplier   = in_work.multiplier >> SLICE_BITS;
        next_work.multiplicand = in_work.multiplicand << SLICE_BITS;
        next_work.branch_mask  = branch_cleared(in_work.branch_mask, clear_mask);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid && !in_killed; // killed packets are taken but thrown away
        end else if (held_killed) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_ready && in_valid) begin
            work_q <= next_work;
        end else begin
            // resolved branches keep dropping out while the packet waits
            work_q.branch_mask <= branch_cleared(work_q.branch_mask, clear_mask);
        end
    end

    // a stalled packet keeps its payload, and its mask only loses cleared bits
    assert property (@(posedge clock) disable iff (reset)
        (valid_q && !out_ready && !held_killed) |=>
            $stable(work_q.partial_sum) &&
            $stable(work_q.multiplier) &&
            $stable(work_q.multiplicand) &&
            $stable(work_q.func) &&
            $stable(work_q.dest_tag) &&
            (work_q.branch_mask ==
                $past(branch_cleared(work_q.branch_mask, clear_mask))));

    assert property (@(posedge clock) !reset |-> !$isunknown(valid_q));

endmodule

/* src/mult_unit.sv */
`timescale 1ns/1ns

module mult_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  rv_core_pkg::mult_issue_t  issue,
    output logic                      cdb_valid,
    input  logic                      cdb_ready,
    output rv_core_pkg::cdb_packet_t  cdb,
    input  rv_core_pkg::branch_mask_t squash_mask,
    input  rv_core_pkg::branch_mask_t clear_mask
);
    import rv_core_pkg::*;
    import mult_pkg::*;

    // entry i is the input of stage i, entry MULT_STAGES is the output of the last stage
    logic [MULT_STAGES:0] chain_valid;
    logic [MULT_STAGES:0] chain_ready;
    mult_work_t           chain_work [0:MULT_STAGES];

    mult_work_t issue_work;
    mult_work_t final_work;
    data_t      result_word;
    logic       issue_seen;

    // operand preparation
    // source_1 becomes the multiplicand and source_2 the multiplier
    always_comb begin
        issue_work.partial_sum = '0;
        issue_work.func        = issue.func;
        issue_work.dest_tag    = issue.dest_tag;
        issue_work.branch_mask = issue.branch_mask;

        case (issue.func)
            MUL, MULH, MULHSU: begin
                issue_work.multiplicand = {{DATA_BITS{issue.source_1[DATA_BITS-1]}},
                                           issue.source_1};
            end
            default: begin
                issue_work.multiplicand = {{DATA_BITS{1'b0}}, issue.source_1};
            end
        endcase

        case (issue.func)
            MUL, MULH: begin
                issue_work.multiplier = {{DATA_BITS{issue.source_2[DATA_BITS-1]}},
                                         issue.source_2};
            end
            default: begin
                issue_work.multiplier = {{DATA_BITS{1'b0}}, issue.source_2};
            end
        endcase
    end

    assign chain_valid[0] = issue_valid;
    assign chain_work[0]  = issue_work;
    assign issue_ready    = chain_ready[0];

    // the ready path runs combinationally from the CDB back to the issue port
    assign chain_ready[MULT_STAGES] = cdb_ready;

    for (genvar i = 0; i < MULT_STAGES; i++) begin : stage_g
        mult_stage stage_i (
            .clock       (clock),
            .reset       (reset),
            .in_valid    (chain_valid[i]),
            .in_ready    (chain_ready[i]),
            .in_work     (chain_work[i]),
            .out_valid   (chain_valid[i+1]),
            .out_ready   (chain_ready[i+1]),
            .out_work    (chain_work[i+1]),
            .squash_mask (squash_mask),
            .clear_mask  (clear_mask)
        );
    end

    assign final_work = chain_work[MULT_STAGES];

    // MUL returns the low word, every MULH variant the high word
    always_comb begin
        if (final_work.func == MUL) begin
            result_word = final_work.partial_sum[DATA_BITS-1:0];
        end else begin
            result_word = final_work.partial_sum[PRODUCT_BITS-1:DATA_BITS];
        end
    end

    assign cdb_valid       = chain_valid[MULT_STAGES]; // already gated by squash in the last stage
    assign cdb.result      = result_word;
    assign cdb.dest_tag    = final_work.dest_tag;
    assign cdb.branch_mask = branch_cleared(final_work.branch_mask, clear_mask);

    // remembers that at least one packet has entered the pipeline since reset
    always_ff @(posedge clock) begin
        if (reset) begin
            issue_seen <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            issue_seen <= 1'b1;
        end
    end

    // nothing can come out of the last stage unless the issue port took a packet before
    assert property (@(posedge clock) disable iff (reset)
        $rose(cdb_valid) |-> issue_seen);

endmodule

/* test/mult_unit_scoreboard.sv */
`timescale 1ns/1ns

module mult_unit_scoreboard (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  logic                      issue_ready,
    input  rv_core_pkg::mult_issue_t  issue,
    input  logic                      cdb_valid,
    input  logic                      cdb_ready,
    input  rv_core_pkg::cdb_packet_t  cdb,
    input  rv_core_pkg::branch_mask_t squash_mask,
    input  rv_core_pkg::branch_mask_t clear_mask,
    input  logic                      check_latency,
    output int                        error_count,
    output int                        compare_count,
    output int                        pending,
    output int                        killed_count
);
    import rv_core_pkg::*;
    import mult_pkg::*;

    cdb_packet_t expected_q [$];     // packets still inside the unit, oldest first
    int          accept_cycle_q [$]; // cycle in which each of them was accepted
    int          cycle         = 0;
    int          check_errors  = 0;
    int          assert_errors = 0;
    int          compares      = 0;
    int          killed        = 0;

    assign error_count   = check_errors + assert_errors;
    assign compare_count = compares;
    assign killed_count  = killed;

    // RV32 M semantics computed with plain 64-bit arithmetic
    function automatic data_t expected_result(input mult_issue_t packet);
        longint multiplicand;
        longint multiplier;
        longint product;
        if (packet.func == MULHU) begin
            multiplicand = {32'b0, packet.source_1};
        end else begin
            multiplicand = $signed(packet.source_1);
        end
        if (packet.func == MUL || packet.func == MULH) begin
            multiplier = $signed(packet.source_2);
        end else begin
            multiplier = {32'b0, packet.source_2};
        end
        product = multiplicand * multiplier;
        return (packet.func == MUL) ? product[31:0] : product[63:32];
    endfunction

    task automatic remove_killed();
        cdb_packet_t kept_q [$];
        int          kept_cycle_q [$];
        for (int i = 0; i < expected_q.size(); i++) begin
            if (branch_killed(expected_q[i].branch_mask, squash_mask)) begin
                killed++;
            end else begin
                kept_q.push_back(expected_q[i]);
                kept_cycle_q.push_back(accept_cycle_q[i]);
            end
        end
        expected_q     = kept_q;
        accept_cycle_q = kept_cycle_q;
    endtask

    task automatic compare_head();
        cdb_packet_t expected;
        int          latency;
        expected = expected_q.pop_front();
        latency  = cycle - accept_cycle_q.pop_front();
        compares++;
        assert (cdb.result == expected.result) else begin
            $display("mismatch at %0t: cdb.result expected %h got %h",
                     $time, expected.result, cdb.result);
            check_errors++;
        end
        assert (cdb.dest_tag == expected.dest_tag) else begin
            $display("mismatch at %0t: cdb.dest_tag expected %0d got %0d",
                     $time, expected.dest_tag, cdb.dest_tag);
            check_errors++;
        end
        assert (cdb.branch_mask == expected.branch_mask) else begin
            $display("mismatch at %0t: cdb.branch_mask expected %b got %b",
                     $time, expected.branch_mask, cdb.branch_mask);
            check_errors++;
        end
        if (check_latency) begin
            assert (latency == MULT_STAGES) else begin
                $display("mismatch at %0t: latency expected %0d got %0d",
                         $time, MULT_STAGES, latency);
                check_errors++;
            end
        end
    endtask

    // inputs only move just after the rising edge, so the falling edge sees
    // exactly what the next rising edge will act on
    always @(negedge clock) begin
        if (reset) begin
            expected_q.delete();
            accept_cycle_q.delete();
        end else begin
            cycle++;
            if (!issue_ready) begin
                assert (!cdb_ready && expected_q.size() == MULT_STAGES) else begin
                    $display("issue_ready was low with only %0d packets inside at %0t",
                             expected_q.size(), $time);
                    check_errors++;
                end
            end
            if (squash_mask != '0) begin
                remove_killed(); // a kill sees the mask before this cycle's clear
            end
            for (int i = 0; i < expected_q.size(); i++) begin
                expected_q[i].branch_mask = branch_cleared(expected_q[i].branch_mask,
                                                           clear_mask);
            end
            if (cdb_valid && cdb_ready) begin
                if (expected_q.size() == 0) begin
                    $display("a packet appeared on the CDB with none expected at %0t", $time);
                    check_errors++;
                end else begin
                    compare_head();
                end
            end
            if (issue_valid && issue_ready) begin
                if (branch_killed(issue.branch_mask, squash_mask)) begin
                    killed++; // taken at the port but dropped at once
                end else begin
                    expected_q.push_back(cdb_packet_t'{
                        result:      expected_result(issue),
                        dest_tag:    issue.dest_tag,
                        branch_mask: branch_cleared(issue.branch_mask, clear_mask)
                    });
                    accept_cycle_q.push_back(cycle);
                end
            end
        end
        pending = expected_q.size();
    end

    // a stalled result may only vanish through a squash or lose cleared mask bits
    assert property (@(posedge clock) disable iff (reset)
        (cdb_valid && !cdb_ready) |=>
            (!cdb_valid && squash_mask != '0) ||
            (cdb_valid && $stable(cdb.result) && $stable(cdb.dest_tag) &&
             ((cdb.branch_mask & ~$past(cdb.branch_mask)) == '0)))
    else begin
        $display("the CDB packet changed while it was stalled at %0t", $time);
        assert_errors++;
    end

    assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> !$isunknown(cdb))
    else begin
        $display("the CDB packet held unknown bits while valid at %0t", $time);
        assert_errors++;
    end

endmodule

/* test/mult_unit_tb.sv */
`timescale 1ns/1ns

module mult_unit_tb;
    import rv_core_pkg::*;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 200; // cycles any single wait may take

    logic         clock;
    logic         reset;
    logic         issue_valid;
    logic         issue_ready;
    mult_issue_t  issue;
    logic         cdb_valid;
    logic         cdb_ready;
    cdb_packet_t  cdb;
    branch_mask_t squash_mask;
    branch_mask_t clear_mask;

    logic check_latency;
    logic ready_random;  // cdb_ready follows a coin flip instead of staying high
    logic branch_random; // occasional squash and clear pulses
    logic timed_out;
    int   seed;          // packet contents
    int   side_seed;     // cdb_ready and branch pulses
    int   tb_errors;
    int   tests_run;
    int   sb_errors;
    int   sb_compares;
    int   sb_pending;
    int   sb_killed;

    mult_unit dut_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .cdb_valid   (cdb_valid),
        .cdb_ready   (cdb_ready),
        .cdb         (cdb),
        .squash_mask (squash_mask),
        .clear_mask  (clear_mask)
    );

    mult_unit_scoreboard scoreboard_i (
        .clock         (clock),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue         (issue),
        .cdb_valid     (cdb_valid),
        .cdb_ready     (cdb_ready),
        .cdb           (cdb),
        .squash_mask   (squash_mask),
        .clear_mask    (clear_mask),
        .check_latency (check_latency),
        .error_count   (sb_errors),
        .compare_count (sb_compares),
        .pending       (sb_pending),
        .killed_count  (sb_killed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    function automatic int total_errors();
        return sb_errors + tb_errors;
    endfunction

    task automatic report_timeout(input string what);
        if (!timed_out) begin
            $display("timeout: %s after %0d cycles at %0t", what, WAIT_LIMIT, $time);
        end
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errors_before);
    endtask

    function automatic mult_issue_t build_packet(input data_t s1, input data_t s2,
                                                 input mult_func_t func, input int tag);
        mult_issue_t packet;
        packet.source_1    = s1;
        packet.source_2    = s2;
        packet.func        = func;
        packet.dest_tag    = phys_reg_t'(tag);
        packet.branch_mask = '0;
        return packet;
    endfunction

    function automatic mult_issue_t random_packet(input logic with_mask);
        mult_issue_t packet;
        packet.source_1    = $random(seed);
        packet.source_2    = $random(seed);
        packet.func        = mult_func_t'($random(seed) & 3);
        packet.dest_tag    = phys_reg_t'($random(seed));
        packet.branch_mask = with_mask ? branch_mask_t'($random(seed)) : '0;
        return packet;
    endfunction

    // holds the packet on the issue port until the unit takes it
    task automatic issue_packet(input mult_issue_t packet);
        logic accepted;
        int   waited;
        accepted = 1'b0;
        waited   = 0;
        if (!timed_out) begin
            issue       = packet;
            issue_valid = 1'b1;
        end
        while (!accepted && !timed_out) begin
            #2;
            accepted = issue_ready; // settled well before the next edge
            next_cycle();
            waited++;
            if (!accepted && waited >= WAIT_LIMIT) begin
                report_timeout("the issue port never became ready");
            end
        end
        issue_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (!timed_out && sb_pending != 0) begin
            next_cycle();
            waited++;
            if (waited >= WAIT_LIMIT) begin
                report_timeout("the pipeline did not drain");
            end
        end
    endtask

    // cdb_ready and the branch broadcast come from their own process
    initial begin
        logic ready_mode;
        logic branch_mode;
        int   pick;
        side_seed   = 32'hb58d_9521;
        cdb_ready   = 1'b1;
        squash_mask = '0;
        clear_mask  = '0;
        forever begin
            @(posedge clock);
            ready_mode  = ready_random;
            branch_mode = branch_random;
            #1;
            cdb_ready   = ready_mode ? 1'($random(side_seed)) : 1'b1;
            squash_mask = '0;
            clear_mask  = '0;
            if (branch_mode) begin
                pick = $random(side_seed);
                if (pick[3:0] == 4'd0) begin
                    squash_mask = branch_mask_t'(1) << (pick[7:4] % BRANCH_DEPTH);
                end else if (pick[3:0] == 4'd1) begin
                    clear_mask = branch_mask_t'(1) << (pick[7:4] % BRANCH_DEPTH);
                end
            end
        end
    end

    initial begin
        data_t corner_values [0:5];
        int    errors_before;
        int    kills_before;
        int    tag;
        time   start_time;
        seed          = 32'hb58d_9521;
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue         = '0;
        check_latency = 1'b0;
        ready_random  = 1'b0;
        branch_random = 1'b0;
        timed_out     = 1'b0;
        tb_errors     = 0;
        tests_run     = 0;
        corner_values = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                          32'h8000_0000, 32'h7fff_ffff, 32'hfedc_ba98};
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        errors_before = total_errors();
        #2;
        assert (cdb_valid == 1'b0) else begin
            $display("mismatch at %0t: cdb_valid expected 0 got %b", $time, cdb_valid);
            tb_errors++;
        end
        assert (issue_ready == 1'b1) else begin
            $display("mismatch at %0t: issue_ready expected 1 got %b", $time, issue_ready);
            tb_errors++;
        end
        next_cycle();
        finish_test("reset state", errors_before);

        errors_before = total_errors();
        tag = 0;
        for (int f = 0; f < 4; f++) begin
            for (int a = 0; a < 6; a++) begin
                for (int b = 0; b < 6; b++) begin
                    issue_packet(build_packet(corner_values[a], corner_values[b],
                                              mult_func_t'(f), tag));
                    tag++;
                end
            end
        end
        wait_for_drain();
        finish_test("corner operands", errors_before);

        errors_before = total_errors();
        check_latency = 1'b1;
        start_time    = $time;
        for (int i = 0; i < 32; i++) begin
            issue_packet(random_packet(1'b0));
        end
        assert (($time - start_time) / CLOCK_PERIOD == 32) else begin
            $display("mismatch at %0t: issue cycles expected 32 got %0d",
                     $time, ($time - start_time) / CLOCK_PERIOD);
            tb_errors++;
        end
        wait_for_drain();
        check_latency = 1'b0;
        finish_test("back-to-back issue", errors_before);

        errors_before = total_errors();
        ready_random  = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (($random(seed) & 3) == 0) begin
                next_cycle(); // an idle cycle on the issue port
            end
            issue_packet(random_packet(1'b0));
        end
        wait_for_drain();
        finish_test("random back-pressure", errors_before);

        errors_before = total_errors();
        kills_before  = sb_killed;
        branch_random = 1'b1;
        for (int i = 0; i < 48; i++) begin
            issue_packet(random_packet(1'b1));
        end
        wait_for_drain();
        branch_random = 1'b0;
        ready_random  = 1'b0;
        next_cycle();
        assert (sb_killed > kills_before) else begin
            $display("no packet was squashed during the branch test");
            tb_errors++;
        end
        finish_test("branch squash and clear", errors_before);

        errors_before = total_errors();
        assert (sb_pending == 0) else begin
            $display("mismatch at %0t: queue size expected 0 got %0d", $time, sb_pending);
            tb_errors++;
        end
        assert (sb_compares > 0) else begin
            $display("no packet ever reached the CDB");
            tb_errors++;
        end
        finish_test("empty queue", errors_before);

        $display("tests run %0d, packets compared %0d, packets squashed %0d, errors %0d",
                 tests_run, sb_compares, sb_killed, total_errors());
        if (timed_out || total_errors() != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

/* mult_unit.f */
src/rv_core_pkg.sv
src/mult_pkg.sv
src/mult_stage.sv
src/mult_unit.sv
test/mult_unit_scoreboard.sv
test/mult_unit_tb.sv

/* Bender.yml */
package:
  name: mult_unit

sources:
  # packages first, then the stage and the top level
  - src/rv_core_pkg.sv
  - src/mult_pkg.sv
  - src/mult_stage.sv
  - src/mult_unit.sv

  # simulation only
  - target: test
    files:
      - test/mult_unit_scoreboard.sv
      - test/mult_unit_tb.sv
